//--- Bender.yml
package:
  name: stat_core

sources:
  - hw/stat_pkg.sv
  - hw/stat_inc_if.sv
  - hw/stat_arb_mux.sv
  - hw/stat_counter.sv
  - hw/stat_core.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_stat_checker.sv
      - verification/tb_stat_core.sv

//--- build.f
hw/stat_pkg.sv
hw/stat_inc_if.sv
hw/stat_arb_mux.sv
hw/stat_counter.sv
hw/stat_core.sv
verification/tb_clk_gen.sv
verification/tb_stat_checker.sv
verification/tb_stat_core.sv

//--- hw/stat_arb_mux.sv
// Round-robin increment arbiter

`timescale 1ns/1ps

module stat_arb_mux #(
    parameter int S_COUNT = stat_pkg::STAT_SRC_COUNT
) (
    input  logic      clk,
    input  logic      rst_n,

    // Increment streams in
    stat_inc_if.sink  s [S_COUNT],

    // Merged stream out
    stat_inc_if.source m
);

    typedef logic [$clog2(S_COUNT)-1:0] idx_t;

    logic [S_COUNT-1:0]  req;
    logic [S_COUNT-1:0]  ready_vec;
    stat_pkg::stat_id_t  id_arr [S_COUNT];
    stat_pkg::stat_inc_t inc_arr [S_COUNT];

    logic                gnt_found;
    idx_t                gnt_idx;
    logic                grant;
    logic                can_accept;
    idx_t                last_q;

    logic                out_valid;
    stat_pkg::stat_id_t  out_id;
    stat_pkg::stat_inc_t out_inc;

    // Flatten the interface array so it can be indexed by the grant
    for (genvar i = 0; i < S_COUNT; i++) begin : g_src
        assign req[i] = s[i].valid;
        assign id_arr[i] = s[i].id;
        assign inc_arr[i] = s[i].inc;
        assign ready_vec[i] = grant && (gnt_idx == idx_t'(i));
        assign s[i].ready = ready_vec[i];
    end

    // Output slot is free when empty or being drained this cycle
    assign can_accept = !out_valid || m.ready;

    // Search starts one past the last granted source
    always_comb begin
        int cand;
        gnt_found = 1'b0;
        gnt_idx = last_q;
        for (int off = 1; off <= S_COUNT; off++) begin
            cand = (int'(last_q) + off) % S_COUNT;
            if (!gnt_found && req[cand]) begin
                gnt_found = 1'b1;
                gnt_idx = idx_t'(cand);
            end
        end
    end

    assign grant = gnt_found && can_accept;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            // Source 0 wins the first tie
            last_q <= idx_t'(S_COUNT - 1);
        end else begin
            if (grant) begin
                out_valid <= 1'b1;
                last_q <= gnt_idx;
            end else if (m.ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            out_id <= id_arr[gnt_idx];
            out_inc <= inc_arr[gnt_idx];
        end
    end

    assign m.valid = out_valid;
    assign m.id = out_id;
    assign m.inc = out_inc;

    // A source never wins twice running while every source requests
    for (genvar i = 0; i < S_COUNT; i++) begin : g_rr_check
        a_rr_turn : assert property (
            @(posedge clk) disable iff (!rst_n)
            ready_vec[i] |=> !(&req && ready_vec[i])
        );
    end

    // Stalled output keeps its payload
    a_out_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        m.valid && !m.ready |=> m.valid && $stable(m.id) && $stable(m.inc)
    );

endmodule

//--- hw/stat_core.sv
// Statistics collection top level

`timescale 1ns/1ps

module stat_core (
    input  logic                   clk,
    input  logic                   rst_n,

    // Increment source 0
    input  logic                   src0_valid,
    output logic                   src0_ready,
    input  stat_pkg::stat_id_t     src0_id,
    input  stat_pkg::stat_inc_t    src0_inc,

    // Increment source 1
    input  logic                   src1_valid,
    output logic                   src1_ready,
    input  stat_pkg::stat_id_t     src1_id,
    input  stat_pkg::stat_inc_t    src1_inc,

    // Counter read port
    input  logic                   rd_en,
    input  stat_pkg::stat_id_t     rd_id,
    input  logic                   rd_clear,
    output logic                   rd_valid,
    output stat_pkg::stat_count_t  rd_count
);

    stat_inc_if src_if [stat_pkg::STAT_SRC_COUNT] ();
    stat_inc_if arb_if ();

    // Source ports onto the stream array
    assign src_if[0].valid = src0_valid;
    assign src_if[0].id = src0_id;
    assign src_if[0].inc = src0_inc;
    assign src0_ready = src_if[0].ready;

    assign src_if[1].valid = src1_valid;
    assign src_if[1].id = src1_id;
    assign src_if[1].inc = src1_inc;
    assign src1_ready = src_if[1].ready;

    stat_arb_mux #(
        .S_COUNT(stat_pkg::STAT_SRC_COUNT)
    ) stat_arb_mux_i (
        .clk(clk),
        .rst_n(rst_n),
        .s(src_if),
        .m(arb_if)
    );

    stat_counter stat_counter_i (
        .clk(clk),
        .rst_n(rst_n),
        .upd(arb_if),
        .rd_en(rd_en),
        .rd_id(rd_id),
        .rd_clear(rd_clear),
        .rd_valid(rd_valid),
        .rd_count(rd_count)
    );

endmodule

//--- hw/stat_counter.sv
// Statistics counter memory

`timescale 1ns/1ps

module stat_counter (
    input  logic                   clk,
    input  logic                   rst_n,

    // Merged increment stream
    stat_inc_if.sink               upd,

    // Host read port
    input  logic                   rd_en,
    input  stat_pkg::stat_id_t     rd_id,
    input  logic                   rd_clear,
    output logic                   rd_valid,
    output stat_pkg::stat_count_t  rd_count
);

    stat_pkg::stat_count_t mem [stat_pkg::STAT_COUNT];

    // Clear sweep after reset
    logic                  init_busy;
    stat_pkg::stat_id_t    init_ptr;

    // Operation entering the pipeline
    logic                  acc_upd;
    logic                  op_valid;
    stat_pkg::stat_id_t    op_id;
    stat_pkg::stat_inc_t   op_inc;

    // Stage one, memory read
    logic                  s1_valid;
    logic                  s1_rd;
    logic                  s1_clr;
    logic                  s1_unswept;
    stat_pkg::stat_id_t    s1_id;
    stat_pkg::stat_inc_t   s1_inc;
    stat_pkg::stat_count_t s1_mem;

    // Stage two, value just written back
    logic                  s2_valid;
    stat_pkg::stat_id_t    s2_id;
    stat_pkg::stat_count_t s2_val;

    stat_pkg::stat_count_t base;
    stat_pkg::stat_count_t next_val;

    logic                  wr_en;
    stat_pkg::stat_id_t    wr_addr;
    stat_pkg::stat_count_t wr_data;

    // Reads win over updates
    assign upd.ready = !init_busy && !rd_en;
    assign acc_upd = upd.valid && upd.ready;
    assign op_valid = rd_en || acc_upd;
    assign op_id = rd_en ? rd_id : upd.id;
    // A read passes through the adder with zero
    assign op_inc = rd_en ? '0 : upd.inc;

    // Previous op wrote this counter after our read
    always_comb begin
        if (s2_valid && s2_id == s1_id) begin
            base = s2_val;
        end else if (s1_unswept) begin
            base = '0;
        end else begin
            base = s1_mem;
        end
    end

    assign next_val = s1_clr ? '0 : base + stat_pkg::stat_count_t'(s1_inc);

    // Single write port shared by the sweep and stage two
    assign wr_en = init_busy || s1_valid;
    assign wr_addr = init_busy ? init_ptr : s1_id;
    assign wr_data = init_busy ? '0 : next_val;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_busy <= 1'b1;
            init_ptr <= '0;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            if (init_busy) begin
                init_ptr <= init_ptr + 1'b1;
                if (init_ptr == stat_pkg::stat_id_t'(stat_pkg::STAT_COUNT - 1)) begin
                    init_busy <= 1'b0;
                end
            end
            s1_valid <= op_valid;
            s2_valid <= s1_valid;
            rd_valid <= s1_valid && s1_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            s1_id <= op_id;
            s1_inc <= op_inc;
            s1_rd <= rd_en;
            s1_clr <= rd_en && rd_clear;
            // Counter not yet reached by the sweep still holds garbage
            s1_unswept <= init_busy && (op_id >= init_ptr);
            s1_mem <= mem[op_id];
        end
        if (s1_valid) begin
            s2_id <= s1_id;
            s2_val <= next_val;
            rd_count <= base;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read result two cycles after the request, and never otherwise
    a_rd_latency : assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_en |-> ##2 rd_valid
    );

    a_rd_no_spurious : assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_valid |-> $past(rd_en, 2)
    );

    // Update offered during a read stays pending
    a_rd_stalls_upd : assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_en && upd.valid |=> upd.valid && $stable(upd.id) && $stable(upd.inc)
    );

endmodule

//--- hw/stat_inc_if.sv
// Statistics increment stream

`timescale 1ns/1ps

interface stat_inc_if;

    logic                 valid;
    logic                 ready;
    stat_pkg::stat_id_t   id;
    stat_pkg::stat_inc_t  inc;

    // Producer side of the stream
    modport source (
        output valid,
        input  ready,
        output id,
        output inc
    );

    // Consumer side of the stream
    modport sink (
        input  valid,
        output ready,
        input  id,
        input  inc
    );

endinterface

//--- hw/stat_pkg.sv
// Statistics subsystem definitions

package stat_pkg;

    // Counter addressing
    localparam int STAT_ID_W = 4;
    localparam int STAT_COUNT = 16;

    // Increment and counter widths
    localparam int STAT_INC_W = 8;
    localparam int STAT_COUNT_W = 32;

    // Number of increment streams merged by the arbiter
    localparam int STAT_SRC_COUNT = 2;

    // Index of one counter
    typedef logic [STAT_ID_W-1:0] stat_id_t;

    // Amount added per update
    typedef logic [STAT_INC_W-1:0] stat_inc_t;

    // Counter value that wraps modulo 2**32
    typedef logic [STAT_COUNT_W-1:0] stat_count_t;

endpackage

//--- verification/stat_tests.txt
// Columns kind_flag_id_cycles_value, all hex
// Kind 1 update (flag source, value inc), 2 read (flag clear, value expected), 3 wait, 4 fairness
3_0_0_0014_00000000
2_0_0_0000_00000000
2_0_1_0000_00000000
2_0_2_0000_00000000
2_0_3_0000_00000000
2_0_4_0000_00000000
2_0_5_0000_00000000
2_0_6_0000_00000000
2_0_7_0000_00000000
2_0_8_0000_00000000
2_0_9_0000_00000000
2_0_a_0000_00000000
2_0_b_0000_00000000
2_0_c_0000_00000000
2_0_d_0000_00000000
2_0_e_0000_00000000
2_0_f_0000_00000000
// One source, several counters
1_0_1_0000_00000010
1_0_2_0000_000000ff
1_0_1_0000_00000005
1_0_3_0000_00000080
1_0_2_0000_00000001
3_0_0_0004_00000000
2_0_1_0000_00000015
2_0_2_0000_00000100
2_0_3_0000_00000080
// Both sources on counter 4
1_0_4_0000_00000011
1_1_4_0000_00000022
1_0_4_0000_00000033
1_1_4_0000_00000044
1_0_4_0000_000000ff
1_1_4_0000_00000001
3_0_0_0004_00000000
2_0_4_0000_000001aa
// Ten cycles of both sources on counter 5, three each
4_0_5_000a_00000003
3_0_0_0004_00000000
2_0_5_0000_0000001e
// Clearing read, then new increments
2_1_4_0000_000001aa
1_0_4_0000_00000007
1_1_4_0000_00000009
3_0_0_0004_00000000
2_0_4_0000_00000010
// Reads while both sources are busy
1_0_6_0000_00000020
1_1_7_0000_00000030
1_0_6_0000_00000020
1_1_7_0000_00000030
2_0_1_0000_00000015
2_0_2_0000_00000100
3_0_0_0004_00000000
2_0_6_0000_00000040
2_0_7_0000_00000060

//--- verification/tb_clk_gen.sv
// Testbench clock and reset

`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held for five rising edges
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- verification/tb_stat_checker.sv
// Read result and handshake checker

`timescale 1ns/1ps

module tb_stat_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  src0_ready,
    input  logic                  src1_ready,
    input  logic                  fair_active,
    input  logic                  rd_valid,
    input  stat_pkg::stat_count_t rd_count,
    output int                    pass_cnt,
    output int                    fail_cnt,
    output int                    outstanding
);

    stat_pkg::stat_count_t exp_q [$];
    int                    id_q [$];
    int                    age;
    logic                  match;
    logic                  reset_bad;
    int                    fair_n [2];
    int                    fair_last;
    int                    fair_cur;
    logic                  fair_repeat;

    initial begin
        pass_cnt = 0;
        fail_cnt = 0;
        outstanding = 0;
        age = 0;
        reset_bad = 1'b0;
        fair_n[0] = 0;
        fair_n[1] = 0;
        fair_last = -1;
        fair_repeat = 1'b0;
    end

    task automatic record_result(input logic ok, input string what);
        if (ok) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("test %0d %s: %s", pass_cnt + fail_cnt, what, ok ? "pass" : "fail");
    endtask

    // Queued by the testbench as it issues each read
    task automatic expect_read(input int id, input stat_pkg::stat_count_t value);
        exp_q.push_back(value);
        id_q.push_back(id);
        outstanding = exp_q.size();
    endtask

    task automatic pop_expected();
        void'(exp_q.pop_front());
        void'(id_q.pop_front());
        outstanding = exp_q.size();
        age = 0;
    endtask

    // End of a fairness window
    task automatic finish_fairness();
        int diff;
        diff = fair_n[0] - fair_n[1];
        if (fair_repeat) begin
            $display("ready pulses did not alternate between the two sources");
        end
        if (diff > 1 || diff < -1) begin
            $display("transfer counts %0d and %0d differ by more than one", fair_n[0], fair_n[1]);
        end
        record_result(!fair_repeat && diff <= 1 && diff >= -1, "fairness");
        fair_n[0] = 0;
        fair_n[1] = 0;
        fair_last = -1;
        fair_repeat = 1'b0;
    endtask

    always @(posedge rst_n) begin
        if (reset_bad) begin
            $display("a source ready or rd_valid was high during reset");
        end
        record_result(!reset_bad, "outputs low in reset");
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            if (src0_ready !== 1'b0 || src1_ready !== 1'b0 || rd_valid !== 1'b0) begin
                reset_bad = 1'b1;
            end
        end else begin
            if (fair_active && (src0_ready || src1_ready)) begin
                fair_cur = src1_ready ? 1 : 0;
                fair_n[fair_cur]++;
                if (fair_cur == fair_last) begin
                    fair_repeat = 1'b1;
                end
                fair_last = fair_cur;
            end
            if (rd_valid) begin
                if (exp_q.size() == 0) begin
                    $display("rd_valid was high at %0t with no read outstanding", $time);
                    record_result(1'b0, "unexpected read result");
                end else begin
                    match = (rd_count === exp_q[0]);
                    if (!match) begin
                        $display("error at %0t: rd_count got %h expected %h",
                                 $time, rd_count, exp_q[0]);
                    end
                    record_result(match, $sformatf("read counter %0d", id_q[0]));
                    pop_expected();
                end
            end else if (exp_q.size() != 0) begin
                age++;
                if (age > 6) begin
                    $display("read of counter %0d never returned", id_q[0]);
                    record_result(1'b0, "read timeout");
                    pop_expected();
                end
            end
        end
    end

endmodule

//--- verification/tb_stat_core.sv
// Statistics core testbench

`timescale 1ns/1ps

module tb_stat_core;

    localparam string       TEST_FILE = "verification/stat_tests.txt";
    localparam int          MAX_OPS = 64;
    localparam int          TIMEOUT_MARGIN = 100;
    localparam logic [31:0] LCG_SEED = 32'h00eb86d4;

    logic                  clk;
    logic                  rst_n;
    logic [1:0]            src_valid;
    logic [1:0]            src_ready;
    stat_pkg::stat_id_t    src_id [2];
    stat_pkg::stat_inc_t   src_inc [2];
    logic                  rd_en;
    stat_pkg::stat_id_t    rd_id;
    logic                  rd_clear;
    logic                  rd_valid;
    stat_pkg::stat_count_t rd_count;
    logic                  fair_active;
    int                    pass_cnt;
    int                    fail_cnt;
    int                    outstanding;

    // Op word is kind, flag, id, cycles, value
    logic [59:0]           ops [MAX_OPS];
    // Pending updates per source as {id, inc}
    logic [11:0]           upd_q [2][MAX_OPS];
    int                    q_head [2];
    int                    q_tail [2];
    int                    gap [2];
    logic [31:0]           lcg;
    logic                  rd_pend;
    stat_pkg::stat_id_t    pend_id;
    logic                  pend_clr;
    stat_pkg::stat_count_t pend_exp;
    int                    cycle_cnt;
    int                    timeout_limit;

    tb_clk_gen tb_clk_gen_i (
        .clk(clk),
        .rst_n(rst_n)
    );

    stat_core stat_core_i (
        .clk(clk),
        .rst_n(rst_n),
        .src0_valid(src_valid[0]),
        .src0_ready(src_ready[0]),
        .src0_id(src_id[0]),
        .src0_inc(src_inc[0]),
        .src1_valid(src_valid[1]),
        .src1_ready(src_ready[1]),
        .src1_id(src_id[1]),
        .src1_inc(src_inc[1]),
        .rd_en(rd_en),
        .rd_id(rd_id),
        .rd_clear(rd_clear),
        .rd_valid(rd_valid),
        .rd_count(rd_count)
    );

    tb_stat_checker tb_stat_checker_i (
        .clk(clk),
        .rst_n(rst_n),
        .src0_ready(src_ready[0]),
        .src1_ready(src_ready[1]),
        .fair_active(fair_active),
        .rd_valid(rd_valid),
        .rd_count(rd_count),
        .pass_cnt(pass_cnt),
        .fail_cnt(fail_cnt),
        .outstanding(outstanding)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // Idle gap of zero to three cycles, then hold valid until accepted
    task automatic advance_source(input int s, input logic hs);
        if (hs) begin
            q_head[s]++;
            lcg = lcg_next(lcg);
            gap[s] = int'(lcg[17:16]);
        end
        if (hs || !src_valid[s]) begin
            if (gap[s] > 0 || q_head[s] == q_tail[s]) begin
                src_valid[s] <= 1'b0;
                if (gap[s] > 0) begin
                    gap[s]--;
                end
            end else begin
                src_valid[s] <= 1'b1;
                {src_id[s], src_inc[s]} <= upd_q[s][q_head[s]];
            end
        end
    endtask

    // Sample handshakes at the falling edge, drive at the rising edge
    task automatic step_cycle();
        logic [1:0] hs;
        @(negedge clk);
        hs = src_valid & src_ready;
        @(posedge clk);
        advance_source(0, hs[0]);
        advance_source(1, hs[1]);
        if (rd_pend) begin
            rd_id <= pend_id;
            rd_clear <= pend_clr;
            tb_stat_checker_i.expect_read(int'(pend_id), pend_exp);
        end
        rd_en <= rd_pend;
        rd_pend = 1'b0;
    endtask

    task automatic drain_sources();
        do begin
            step_cycle();
        end while (q_head[0] != q_tail[0] || q_head[1] != q_tail[1] || src_valid != 2'b00);
    endtask

    // Both sources request the same counter for a fixed window
    task automatic run_fairness(input int n, input stat_pkg::stat_id_t id,
                                input stat_pkg::stat_inc_t inc);
        drain_sources();
        src_valid <= 2'b11;
        src_id[0] <= id;
        src_id[1] <= id;
        src_inc[0] <= inc;
        src_inc[1] <= inc;
        fair_active <= 1'b1;
        repeat (n) @(posedge clk);
        src_valid <= 2'b00;
        fair_active <= 1'b0;
        tb_stat_checker_i.finish_fairness();
    endtask

    initial begin
        int          i;
        int          total;
        logic [59:0] op;
        src_valid = 2'b00;
        for (int s = 0; s < 2; s++) begin
            src_id[s] = '0;
            src_inc[s] = '0;
            q_head[s] = 0;
            q_tail[s] = 0;
            gap[s] = 0;
        end
        rd_en = 1'b0;
        rd_id = '0;
        rd_clear = 1'b0;
        fair_active = 1'b0;
        rd_pend = 1'b0;
        lcg = LCG_SEED;
        for (i = 0; i < MAX_OPS; i++) begin
            ops[i] = '0;
        end
        $readmemh(TEST_FILE, ops);

        // Four cycles per update, plus every wait and fairness window
        total = 0;
        for (i = 0; i < MAX_OPS && ops[i][59:56] != 4'h0; i++) begin
            if (ops[i][59:56] == 4'h1) begin
                total += 4;
            end else if (ops[i][59:56] == 4'h3 || ops[i][59:56] == 4'h4) begin
                total += int'(ops[i][47:32]);
            end
        end
        timeout_limit = total * 4 + TIMEOUT_MARGIN;

        @(posedge rst_n);
        for (i = 0; i < MAX_OPS && ops[i][59:56] != 4'h0; i++) begin
            op = ops[i];
            case (op[59:56])
                4'h1: begin
                    upd_q[op[52]][q_tail[op[52]]] = {op[51:48], op[7:0]};
                    q_tail[op[52]]++;
                end
                4'h2: begin
                    rd_pend = 1'b1;
                    pend_id = op[51:48];
                    pend_clr = op[52];
                    pend_exp = op[31:0];
                    step_cycle();
                end
                4'h3: begin
                    drain_sources();
                    repeat (int'(op[47:32])) step_cycle();
                end
                4'h4: run_fairness(int'(op[47:32]), op[51:48], op[7:0]);
                default: begin
                    $display("unknown operation kind %h in line %0d", op[59:56], i);
                    tb_stat_checker_i.record_result(1'b0, "test file format");
                end
            endcase
        end
        drain_sources();
        while (outstanding != 0) begin
            step_cycle();
        end

        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Cycle limit derived from the test file
    initial begin
        cycle_cnt = 0;
        wait (timeout_limit > 0);
        while (cycle_cnt < timeout_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
        $display("Simulation failed");
        $finish;
    end

endmodule
